/* include/signMag_settings.svh */
// ------------------------------
// Word layout for the sign-magnitude unit
// Sign bit on top, magnitude below, no spare bits
// ------------------------------
`ifndef SIGNMAG_SETTINGS_SVH
`define SIGNMAG_SETTINGS_SVH

`define SM_WIDTH      16
`define SM_MAG_WIDTH  15
`define SM_SIGN_BIT   15

`endif

/* verilog/signMagPkg.sv */
// ------------------------------
// Shared types for the sign-magnitude unit
// Widths come from the settings header
// ------------------------------
`default_nettype none

`include "signMag_settings.svh"

package signMagPkg;

    // One word, sign on the MSB
    typedef struct packed {
        logic                     sign;
        logic [`SM_MAG_WIDTH-1:0] mag;
    } smWord_t;

    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_NEG} aluOp_t;

    typedef struct packed {
        aluOp_t  op;
        smWord_t a;
        smWord_t b;
    } aluReq_t;

    typedef enum logic [2:0] {IDLE, SET, CHECKADD, ADD, FIN} mulState_t;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} seqState_t;

endpackage

`default_nettype wire

/* verilog/adder15.sv */
// ------------------------------
// Ripple adder that subtracts via inverted in2 plus one
// On subtract cOut set means in1 >= in2
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "signMag_settings.svh"

module adder15 (
    input  logic [`SM_MAG_WIDTH-1:0] in1,
    input  logic [`SM_MAG_WIDTH-1:0] in2,
    input  logic                     sub,
    output logic [`SM_MAG_WIDTH-1:0] sum,
    output logic                     cOut
);

    logic [`SM_MAG_WIDTH-1:0] in2Eff;
    logic [`SM_MAG_WIDTH:0]   carry;

    assign in2Eff = in2 ^ {`SM_MAG_WIDTH{sub}};

    always_comb begin
        carry[0] = sub;  // Carry-in of one for two's complement
        for (int i = 0; i < `SM_MAG_WIDTH; i++) begin
            sum[i]     = in1[i] ^ in2Eff[i] ^ carry[i];
            carry[i+1] = (in1[i] & in2Eff[i]) | (carry[i] & (in1[i] ^ in2Eff[i]));
        end
    end

    assign cOut = carry[`SM_MAG_WIDTH];

endmodule

`default_nettype wire

/* verilog/multiply.sv */
// ------------------------------
// Multiply by repeated addition, two cycles per step
// Latency follows |b|, magnitude wraps mod 2^15
// Hold start and operands until finish is seen
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "signMag_settings.svh"

module multiply
    import signMagPkg::*;
(
    input  logic    clk,
    input  logic    nRST,
    input  logic    start,
    input  smWord_t a,
    input  smWord_t b,
    output smWord_t out,
    output logic    finish
);

    mulState_t state, next;

    logic                     sign;
    logic [`SM_MAG_WIDTH-1:0] magA;
    logic [`SM_MAG_WIDTH-1:0] magB;

    // Accumulator path
    logic [`SM_MAG_WIDTH-1:0] accOut;
    logic [`SM_MAG_WIDTH-1:0] accIn;
    logic [`SM_MAG_WIDTH-1:0] accSave;

    // Loop counter path
    logic [`SM_MAG_WIDTH-1:0] cntOut;
    logic [`SM_MAG_WIDTH-1:0] cntIn;
    logic [`SM_MAG_WIDTH-1:0] cntSave;

    logic stopCount;  // Counter has reached |b|

    adder15 accAdder (
        .in1  (magA),
        .in2  (accIn),
        .sub  (1'b0),
        .sum  (accOut),
        .cOut ()
    );

    adder15 cntAdder (
        .in1  (cntIn),
        .in2  (`SM_MAG_WIDTH'(1)),
        .sub  (1'b0),
        .sum  (cntOut),
        .cOut ()
    );

    // Compare only, the difference itself is not needed
    adder15 stopCmp (
        .in1  (cntOut),
        .in2  (magB),
        .sub  (1'b1),
        .sum  (),
        .cOut (stopCount)
    );

    always_comb begin
        next = state;
        case (state)
            IDLE:     if (start) next = SET;
            SET: begin
                if (b.mag == '0) begin
                    next = FIN;  // Skip the loop for |b| = 0
                end else begin
                    next = CHECKADD;
                end
            end
            CHECKADD: next = stopCount ? FIN : ADD;
            ADD:      next = CHECKADD;
            FIN:      if (!start) next = IDLE;
            default:  next = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            finish <= 1'b0;
            out    <= '0;
        end else begin
            state  <= next;
            finish <= (state == FIN);  // One cycle behind FIN entry
            if (state == FIN) begin
                out <= '{sign: sign, mag: accSave};
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            SET: begin
                sign    <= a.sign ^ b.sign;  // Kept even for a zero product
                magA    <= a.mag;
                magB    <= b.mag;
                accIn   <= '0;
                accSave <= '0;
                cntIn   <= '0;
                cntSave <= '0;
            end
            CHECKADD: begin
                accSave <= accOut;
                cntSave <= cntOut;
            end
            ADD: begin
                accIn <= accSave;
                cntIn <= cntSave;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/signMagAddSub.sv */
// ------------------------------
// Combinational sign-magnitude add and subtract
// Magnitude wraps, equal magnitudes give +0
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "signMag_settings.svh"

module signMagAddSub
    import signMagPkg::*;
(
    input  smWord_t a,
    input  smWord_t b,
    input  logic    sub,
    output smWord_t y
);

    logic bSign;        // Sign of b after the subtract flip
    logic signsDiffer;

    logic [`SM_MAG_WIDTH-1:0] diffMag;
    logic                     aGeB;
    logic                     eqMag;

    logic [`SM_MAG_WIDTH-1:0] bigMag;
    logic [`SM_MAG_WIDTH-1:0] smallMag;
    logic [`SM_MAG_WIDTH-1:0] resMag;

    assign bSign       = b.sign ^ sub;
    assign signsDiffer = a.sign ^ bSign;

    // |a| - |b| gives the ordering and the equality test
    adder15 cmpAdder (
        .in1  (a.mag),
        .in2  (b.mag),
        .sub  (1'b1),
        .sum  (diffMag),
        .cOut (aGeB)
    );

    assign eqMag = (diffMag == '0);

    // Larger magnitude first, order is irrelevant for a plain sum
    assign bigMag   = aGeB ? a.mag : b.mag;
    assign smallMag = aGeB ? b.mag : a.mag;

    adder15 magAdder (
        .in1  (bigMag),
        .in2  (smallMag),
        .sub  (signsDiffer),
        .sum  (resMag),
        .cOut ()
    );

    always_comb begin
        y.mag = resMag;
        if (!signsDiffer) begin
            y.sign = a.sign;
        end else if (eqMag) begin
            y.sign = 1'b0;
        end else begin
            y.sign = aGeB ? a.sign : bSign;  // Sign of the larger operand
        end
    end

endmodule

`default_nettype wire

/* verilog/signMagAlu.sv */
// ------------------------------
// Sign-magnitude ALU, one request at a time
// Level handshake: hold start and req until finish
// Multiply latency depends on |b|
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "signMag_settings.svh"

module signMagAlu
    import signMagPkg::*;
(
    input  logic    clk,
    input  logic    nRST,
    input  logic    start,
    input  aluReq_t req,
    output smWord_t result,
    output logic    finish
);

    localparam logic [`SM_WIDTH-1:0] SIGN_MASK = `SM_WIDTH'(1) << `SM_SIGN_BIT;

    seqState_t state, next;

    aluReq_t reqHeld;  // Captured at start

    logic    isMul;
    logic    mulStart;
    logic    mulFinish;
    smWord_t mulOut;
    smWord_t addSubOut;
    smWord_t negOut;
    smWord_t opResult;

    assign isMul = (reqHeld.op == OP_MUL);

    // Dropped as soon as the multiplier reports done
    assign mulStart = (state == S_RUN) && isMul && !mulFinish;

    multiply mulUnit (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mulStart),
        .a      (reqHeld.a),
        .b      (reqHeld.b),
        .out    (mulOut),
        .finish (mulFinish)
    );

    signMagAddSub addSubUnit (
        .a   (reqHeld.a),
        .b   (reqHeld.b),
        .sub (reqHeld.op == OP_SUB),
        .y   (addSubOut)
    );

    assign negOut = reqHeld.a ^ SIGN_MASK;  // Flip sign, keep magnitude

    always_comb begin
        case (reqHeld.op)
            OP_ADD,
            OP_SUB:  opResult = addSubOut;
            OP_MUL:  opResult = mulOut;
            OP_NEG:  opResult = negOut;
            default: opResult = addSubOut;
        endcase
    end

    always_comb begin
        next = state;
        case (state)
            S_IDLE: if (start) next = S_RUN;
            S_RUN: begin
                if (!isMul || mulFinish) begin
                    next = S_DONE;
                end
            end
            S_DONE: if (!start) next = S_IDLE;
            default: next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state  <= S_IDLE;
            result <= '0;
        end else begin
            state <= next;
            if (state == S_RUN && next == S_DONE) begin
                result <= opResult;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            reqHeld <= req;
        end
    end

    assign finish = (state == S_DONE);

endmodule

`default_nettype wire

/* dv/signMagAlu_assert.sv */
// ------------------------------
// Start/finish protocol checks, bound into signMagAlu
// Assumes the requester holds start until finish
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module signMagAlu_assert
    import signMagPkg::*;
(
    input logic      clk,
    input logic      nRST,
    input logic      start,
    input logic      finish,
    input smWord_t   result,
    input seqState_t state
);

    // Reset values
    finishLowInReset: assert property (@(posedge clk) !nRST |-> (!finish && state == S_IDLE))
        else $error("finish or state not at reset value during reset");

    resultHeld: assert property (@(posedge clk) disable iff (!nRST)
        (finish && $past(finish)) |-> $stable(result))
        else $error("result changed while finish was high");

    // Start was sampled on the edge that raised finish
    finishNeedsStart: assert property (@(posedge clk) disable iff (!nRST)
        $rose(finish) |-> $past(start))
        else $error("finish rose without start");

    finishDrops: assert property (@(posedge clk) disable iff (!nRST)
        $fell(start) |-> ##[0:2] !finish)
        else $error("finish did not fall within two cycles of start falling");

endmodule

bind signMagAlu signMagAlu_assert u_assert (
    .clk    (clk),
    .nRST   (nRST),
    .start  (start),
    .finish (finish),
    .result (result),
    .state  (state)
);

`default_nettype wire

/* dv/signMagAlu_tb.sv */
// ------------------------------
// Table-driven testbench for signMagAlu
// Random multiply rows keep |b| <= 200 to bound the run time
// Stops at the first mismatch
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "signMag_settings.svh"

module signMagAlu_tb
    import signMagPkg::*;
();

    localparam int          CLK_PERIOD      = 8;
    localparam int          RESET_CYCLES    = 5;
    localparam int          DRIVE_DELAY     = 1;
    localparam int          NUM_RANDOM      = 16;
    localparam int          MAX_MUL_B       = 200;
    localparam int          NON_MUL_LATENCY = 2;  // Edges from driving start to finish
    localparam longint      MAG_RANGE       = longint'(1) << `SM_MAG_WIDTH;
    localparam int unsigned RAND_SEED       = 32'he316;

    typedef struct packed {
        aluReq_t    req;
        smWord_t    expected;
        logic [3:0] holdCycles;  // Extra cycles start stays high after finish
    } testRow_t;

    logic    clk;
    logic    nRST;
    logic    start;
    aluReq_t req;
    smWord_t result;
    logic    finish;

    testRow_t rows[$];
    int       cycleCount = 0;
    int       cycleLimit = 0;

    signMagAlu u_dut (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start),
        .req    (req),
        .result (result),
        .finish (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, expected);
            abortRun();
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not complete within %0d clock cycles", cycleLimit);
            abortRun();
        end
    end

    function automatic smWord_t makeWord(input logic sign, input longint mag);
        smWord_t w;
        w.sign = sign;
        w.mag  = `SM_MAG_WIDTH'(mag);
        return w;
    endfunction

    // Expected result worked out from the sign-magnitude rules
    function automatic smWord_t modelResult(input aluReq_t r);
        longint  magA;
        longint  magB;
        logic    bSign;
        smWord_t res;
        magA = r.a.mag;
        magB = r.b.mag;
        res  = '0;
        case (r.op)
            OP_ADD,
            OP_SUB: begin
                bSign = r.b.sign ^ (r.op == OP_SUB);
                if (r.a.sign == bSign) begin
                    res = makeWord(r.a.sign, (magA + magB) % MAG_RANGE);
                end else if (magA > magB) begin
                    res = makeWord(r.a.sign, magA - magB);
                end else if (magB > magA) begin
                    res = makeWord(bSign, magB - magA);
                end else begin
                    res = '0;  // Equal magnitudes cancel to +0
                end
            end
            OP_MUL:  res = makeWord(r.a.sign ^ r.b.sign, (magA * magB) % MAG_RANGE);
            default: res = makeWord(~r.a.sign, magA);
        endcase
        return res;
    endfunction

    task automatic addRow(input aluOp_t op, input smWord_t a, input smWord_t b,
                          input smWord_t expected, input int hold);
        testRow_t row;
        row.req.op     = op;
        row.req.a      = a;
        row.req.b      = b;
        row.expected   = expected;
        row.holdCycles = 4'(hold);
        rows.push_back(row);
    endtask

    task automatic buildTable();
        aluReq_t r;
        longint  bMag;
        addRow(OP_ADD, makeWord(0, 3), makeWord(0, 5), makeWord(0, 8), 0);
        addRow(OP_ADD, makeWord(1, 3), makeWord(1, 5), makeWord(1, 8), 0);
        addRow(OP_ADD, makeWord(0, 32767), makeWord(0, 1), makeWord(0, 0), 0);  // Wraps
        addRow(OP_ADD, makeWord(0, 10), makeWord(1, 4), makeWord(0, 6), 0);
        addRow(OP_ADD, makeWord(0, 4), makeWord(1, 10), makeWord(1, 6), 0);
        addRow(OP_ADD, makeWord(1, 9), makeWord(0, 9), makeWord(0, 0), 0);
        addRow(OP_ADD, makeWord(1, 20), makeWord(0, 5), makeWord(1, 15), 0);
        addRow(OP_SUB, makeWord(0, 5), makeWord(0, 3), makeWord(0, 2), 0);
        addRow(OP_SUB, makeWord(0, 3), makeWord(0, 5), makeWord(1, 2), 0);
        addRow(OP_SUB, makeWord(1, 3), makeWord(1, 3), makeWord(0, 0), 0);
        addRow(OP_SUB, makeWord(0, 100), makeWord(1, 50), makeWord(0, 150), 0);
        addRow(OP_SUB, makeWord(1, 100), makeWord(0, 50), makeWord(1, 150), 0);
        addRow(OP_MUL, makeWord(0, 6), makeWord(0, 7), makeWord(0, 42), 0);
        addRow(OP_MUL, makeWord(1, 6), makeWord(0, 7), makeWord(1, 42), 0);
        addRow(OP_MUL, makeWord(1, 12), makeWord(1, 11), makeWord(0, 132), 0);
        addRow(OP_MUL, makeWord(0, 5), makeWord(1, 0), makeWord(1, 0), 0);
        addRow(OP_MUL, makeWord(1, 5), makeWord(0, 0), makeWord(1, 0), 0);
        addRow(OP_MUL, makeWord(0, 0), makeWord(1, 9), makeWord(1, 0), 0);
        addRow(OP_MUL, makeWord(0, 16384), makeWord(0, 2), makeWord(0, 0), 0);
        addRow(OP_MUL, makeWord(0, 1000), makeWord(0, 200), makeWord(0, 3392), 0);
        addRow(OP_NEG, makeWord(0, 25), makeWord(0, 999), makeWord(1, 25), 0);
        addRow(OP_NEG, makeWord(1, 25), makeWord(1, 7), makeWord(0, 25), 0);
        addRow(OP_NEG, makeWord(0, 0), makeWord(0, 0), makeWord(1, 0), 0);
        addRow(OP_ADD, makeWord(1, 7), makeWord(1, 8), makeWord(1, 15), 6);  // Late start drop
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r.op = aluOp_t'($urandom_range(3, 0));
            r.a  = makeWord($urandom_range(1, 0), $urandom_range(MAG_RANGE - 1, 0));
            bMag = (r.op == OP_MUL) ? $urandom_range(MAX_MUL_B, 0)
                                    : $urandom_range(MAG_RANGE - 1, 0);
            r.b  = makeWord($urandom_range(1, 0), bMag);
            addRow(r.op, r.a, r.b, modelResult(r), 0);
        end
    endtask

    task automatic runRow(input testRow_t row);
        int latency;
        int fallCycles;
        latency    = 0;
        fallCycles = 0;
        req        = row.req;
        start      = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            latency++;
        end while (!finish);
        checkValue("result", result, row.expected);
        if (row.req.op != OP_MUL) begin
            checkValue("finishLatency", latency, NON_MUL_LATENCY);
        end
        repeat (row.holdCycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
            checkValue("finish", finish, 1);
            checkValue("result", result, row.expected);
        end
        start = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            fallCycles++;
        end while (finish);
        if (fallCycles > 2) begin
            $display("finish stayed high %0d cycles after start fell", fallCycles);
            abortRun();
        end
    endtask

    initial begin
        nRST  = 1'b0;
        start = 1'b0;
        req   = '0;
        void'($urandom(RAND_SEED));
        buildTable();
        cycleLimit = RESET_CYCLES + rows.size() * (2 * MAX_MUL_B + 10);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        nRST = 1'b1;
        checkValue("finish", finish, 0);
        checkValue("result", result, 0);
        foreach (rows[i]) begin
            runRow(rows[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* signMagAlu.f */
+incdir+include
verilog/signMagPkg.sv
verilog/adder15.sv
verilog/multiply.sv
verilog/signMagAddSub.sv
verilog/signMagAlu.sv
dv/signMagAlu_assert.sv
dv/signMagAlu_tb.sv
